// ==== verilog/sine_tone_pkg.sv ====
/*
 * Sine tone source shared definitions
 * Widths, settings addresses, CORDIC constants and the I/Q sample type
 */
package sine_tone_pkg;

  // Sample and phase formats
  localparam int SAMPLE_W = 16;
  localparam int IQ_W = 2 * SAMPLE_W;
  localparam int PHASE_W = 16;
  localparam int PHASE_PI = 8192;
  localparam int PHASE_HALF_PI = PHASE_PI / 2;
  localparam int SAMPLE_MAX = 2 ** (SAMPLE_W - 1) - 1;
  localparam int SAMPLE_MIN = -(2 ** (SAMPLE_W - 1));

  // CORDIC pipeline
  localparam int CORDIC_STAGES = 14;
  localparam int CORDIC_LATENCY = CORDIC_STAGES + 2;
  localparam int CORDIC_GUARD = 2;
  // Two extra integer bits cover the fold negation and the 1.647 gain
  localparam int CORDIC_W = SAMPLE_W + 2 + CORDIC_GUARD;

  // atan(2^-k) scaled so that PHASE_PI is pi radians
  localparam logic signed [PHASE_W-1:0] CORDIC_ATAN [0:CORDIC_STAGES-1] = '{
    16'sd2048, 16'sd1209, 16'sd639, 16'sd324, 16'sd163, 16'sd81, 16'sd41,
    16'sd20, 16'sd10, 16'sd5, 16'sd3, 16'sd1, 16'sd1, 16'sd0
  };

  // Settings bus
  localparam int SET_ADDR_W = 8;
  localparam int SET_DATA_W = 32;
  localparam logic [SET_ADDR_W-1:0] SR_PHASE_INC = 8'd129;
  localparam logic [SET_ADDR_W-1:0] SR_CARTESIAN = 8'd130;
  localparam logic [SET_ADDR_W-1:0] SR_SPP = 8'd131;
  localparam logic [SET_ADDR_W-1:0] SR_ENABLE = 8'd132;

  // Packetization
  localparam int SPP_W = 16;
  localparam logic [SPP_W-1:0] SPP_DEFAULT = 16'd64;

  // Q in the upper half, I in the lower half
  typedef struct packed {
    logic signed [SAMPLE_W-1:0] q;
    logic signed [SAMPLE_W-1:0] i;
  } iq_pair_t;

  typedef union packed {
    logic [IQ_W-1:0] raw;
    iq_pair_t iq;
  } iq_sample_t;

endpackage

// ==== verilog/tone_settings.sv ====
/*
 * Tone settings registers
 * Loads phase increment, start vector, packet size and enable from bus writes
 */
`timescale 1ns/1ps

module tone_settings (
  input  logic                                       clk,
  input  logic                                       i_reset,
  input  logic                                       i_set_stb,
  input  logic [sine_tone_pkg::SET_ADDR_W-1:0]       i_set_addr,
  input  logic [sine_tone_pkg::SET_DATA_W-1:0]       i_set_data,
  output logic signed [sine_tone_pkg::PHASE_W-1:0]   o_phase_inc,
  output sine_tone_pkg::iq_sample_t                  o_cartesian,
  output logic [sine_tone_pkg::SPP_W-1:0]            o_spp,
  output logic                                       o_enable
);

  logic [sine_tone_pkg::SPP_W-1:0] spp_wr;

  // A zero packet size would never end a packet
  always_comb begin
    spp_wr = i_set_data[sine_tone_pkg::SPP_W-1:0];
    if (spp_wr == '0) begin
      spp_wr = sine_tone_pkg::SPP_W'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_phase_inc <= '0;
      o_cartesian.raw <= '0;
      o_spp <= sine_tone_pkg::SPP_DEFAULT;
      o_enable <= 1'b0;
    end else if (i_set_stb) begin
      case (i_set_addr)
        sine_tone_pkg::SR_PHASE_INC: begin
          o_phase_inc <= i_set_data[sine_tone_pkg::PHASE_W-1:0];
        end
        sine_tone_pkg::SR_CARTESIAN: begin
          o_cartesian.raw <= i_set_data[sine_tone_pkg::IQ_W-1:0];
        end
        sine_tone_pkg::SR_SPP: begin
          o_spp <= spp_wr;
        end
        sine_tone_pkg::SR_ENABLE: begin
          o_enable <= i_set_data[0];
        end
        default: begin
          // Other addresses belong to other blocks on the bus
        end
      endcase
    end
  end

endmodule

// ==== verilog/phase_accumulator.sv ====
/*
 * Phase accumulator
 * Issues one phase per accepted step and steps by the increment, wrapping at pi
 */
`timescale 1ns/1ps

module phase_accumulator (
  input  logic                                       clk,
  input  logic                                       i_reset,
  input  logic                                       i_clear,
  input  logic                                       i_advance,
  input  logic                                       i_enable,
  input  logic signed [sine_tone_pkg::PHASE_W-1:0]   i_phase_inc,
  output logic signed [sine_tone_pkg::PHASE_W-1:0]   o_phase,
  output logic                                       o_phase_valid
);

  logic signed [sine_tone_pkg::PHASE_W-1:0] acc;
  logic signed [sine_tone_pkg::PHASE_W:0]   sum;
  logic signed [sine_tone_pkg::PHASE_W:0]   wrapped;

  // One extra bit so the sum cannot overflow before the wrap
  always_comb begin
    sum = {acc[sine_tone_pkg::PHASE_W-1], acc}
        + {i_phase_inc[sine_tone_pkg::PHASE_W-1], i_phase_inc};
    wrapped = sum;
    if (sum >= sine_tone_pkg::PHASE_PI) begin
      wrapped = sum - (sine_tone_pkg::PHASE_W + 1)'(2 * sine_tone_pkg::PHASE_PI);
    end else if (sum < -sine_tone_pkg::PHASE_PI) begin
      wrapped = sum + (sine_tone_pkg::PHASE_W + 1)'(2 * sine_tone_pkg::PHASE_PI);
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset || i_clear) begin
      acc <= '0;
      o_phase <= '0;
      o_phase_valid <= 1'b0;
    end else begin
      // Tone restarts from phase 0 on every enable
      if (!i_enable) begin
        acc <= '0;
      end
      if (i_advance) begin
        o_phase_valid <= i_enable;
        if (i_enable) begin
          o_phase <= acc;
          acc <= wrapped[sine_tone_pkg::PHASE_W-1:0];
        end
      end
    end
  end

endmodule

// ==== verilog/cordic_rotator.sv ====
/*
 * Pipelined CORDIC rotator
 * Quadrant fold, rotation stages and a round/saturate stage, all stalled by advance
 */
`timescale 1ns/1ps

module cordic_rotator (
  input  logic                                       clk,
  input  logic                                       i_reset,
  input  logic                                       i_clear,
  input  logic                                       i_advance,
  input  logic signed [sine_tone_pkg::PHASE_W-1:0]   i_phase,
  input  logic                                       i_phase_valid,
  input  sine_tone_pkg::iq_sample_t                  i_cartesian,
  output sine_tone_pkg::iq_sample_t                  o_sample,
  output logic                                       o_valid
);

  // Index 0 is the fold output, index k+1 the output of rotation k
  logic signed [sine_tone_pkg::CORDIC_W-1:0] x_q [0:sine_tone_pkg::CORDIC_STAGES];
  logic signed [sine_tone_pkg::CORDIC_W-1:0] y_q [0:sine_tone_pkg::CORDIC_STAGES];
  logic signed [sine_tone_pkg::PHASE_W-1:0]  z_q [0:sine_tone_pkg::CORDIC_STAGES];
  logic [sine_tone_pkg::CORDIC_STAGES:0]     v_q;

  logic signed [sine_tone_pkg::CORDIC_W-1:0] x_in;
  logic signed [sine_tone_pkg::CORDIC_W-1:0] y_in;
  logic signed [sine_tone_pkg::PHASE_W-1:0]  z_in;

  function automatic logic signed [sine_tone_pkg::SAMPLE_W-1:0] round_sat(
    input logic signed [sine_tone_pkg::CORDIC_W-1:0] v
  );
    logic signed [sine_tone_pkg::CORDIC_W-1:0] r;
    r = (v + sine_tone_pkg::CORDIC_W'(2 ** (sine_tone_pkg::CORDIC_GUARD - 1)))
        >>> sine_tone_pkg::CORDIC_GUARD;
    if (r > sine_tone_pkg::SAMPLE_MAX) begin
      return sine_tone_pkg::SAMPLE_W'(sine_tone_pkg::SAMPLE_MAX);
    end else if (r < sine_tone_pkg::SAMPLE_MIN) begin
      return sine_tone_pkg::SAMPLE_W'(sine_tone_pkg::SAMPLE_MIN);
    end
    return r[sine_tone_pkg::SAMPLE_W-1:0];
  endfunction

  // Sign extend the start vector and append the guard bits
  always_comb begin
    x_in = {{2{i_cartesian.iq.i[sine_tone_pkg::SAMPLE_W-1]}}, i_cartesian.iq.i,
            {sine_tone_pkg::CORDIC_GUARD{1'b0}}};
    y_in = {{2{i_cartesian.iq.q[sine_tone_pkg::SAMPLE_W-1]}}, i_cartesian.iq.q,
            {sine_tone_pkg::CORDIC_GUARD{1'b0}}};
    z_in = i_phase;
    // Rotation range is only about +-pi/2, so fold the outer quadrants by pi
    if (i_phase > sine_tone_pkg::PHASE_HALF_PI) begin
      z_in = sine_tone_pkg::PHASE_W'(i_phase - sine_tone_pkg::PHASE_PI);
      x_in = -x_in;
      y_in = -y_in;
    end else if (i_phase < -sine_tone_pkg::PHASE_HALF_PI) begin
      z_in = sine_tone_pkg::PHASE_W'(i_phase + sine_tone_pkg::PHASE_PI);
      x_in = -x_in;
      y_in = -y_in;
    end
  end

  // Datapath
  always_ff @(posedge clk) begin
    if (i_advance) begin
      x_q[0] <= x_in;
      y_q[0] <= y_in;
      z_q[0] <= z_in;
      for (int k = 0; k < sine_tone_pkg::CORDIC_STAGES; k++) begin
        // Drive the residual angle toward zero
        if (!z_q[k][sine_tone_pkg::PHASE_W-1]) begin
          x_q[k+1] <= x_q[k] - (y_q[k] >>> k);
          y_q[k+1] <= y_q[k] + (x_q[k] >>> k);
          z_q[k+1] <= z_q[k] - sine_tone_pkg::CORDIC_ATAN[k];
        end else begin
          x_q[k+1] <= x_q[k] + (y_q[k] >>> k);
          y_q[k+1] <= y_q[k] - (x_q[k] >>> k);
          z_q[k+1] <= z_q[k] + sine_tone_pkg::CORDIC_ATAN[k];
        end
      end
      o_sample.iq.i <= round_sat(x_q[sine_tone_pkg::CORDIC_STAGES]);
      o_sample.iq.q <= round_sat(y_q[sine_tone_pkg::CORDIC_STAGES]);
    end
  end

  // Valid bits follow the data through every stage
  always_ff @(posedge clk) begin
    if (i_reset || i_clear) begin
      v_q <= '0;
      o_valid <= 1'b0;
    end else if (i_advance) begin
      v_q <= {v_q[sine_tone_pkg::CORDIC_STAGES-1:0], i_phase_valid};
      o_valid <= v_q[sine_tone_pkg::CORDIC_STAGES];
    end
  end

endmodule

// ==== verilog/tone_framer.sv ====
/*
 * Tone output framer
 * Single output register with valid/ready, pipeline advance and packet-end flag
 */
`timescale 1ns/1ps

module tone_framer (
  input  logic                                  clk,
  input  logic                                  i_reset,
  input  logic                                  i_clear,
  input  sine_tone_pkg::iq_sample_t             i_sample,
  input  logic                                  i_valid,
  input  logic [sine_tone_pkg::SPP_W-1:0]       i_spp,
  input  logic                                  i_tready,
  output logic                                  o_advance,
  output logic [sine_tone_pkg::IQ_W-1:0]        o_tdata,
  output logic                                  o_tlast,
  output logic                                  o_tvalid
);

  logic [sine_tone_pkg::SPP_W-1:0] pkt_count;
  logic                            pkt_end;

  // Room for a new sample when empty or draining this cycle
  assign o_advance = !o_tvalid || i_tready;

  // Every loaded sample is transferred later, so counting loads counts transfers
  // Compare with >= in case spp shrinks mid-packet
  assign pkt_end = (pkt_count >= i_spp - 1'b1);

  always_ff @(posedge clk) begin
    if (i_reset || i_clear) begin
      o_tvalid <= 1'b0;
      o_tlast <= 1'b0;
      pkt_count <= '0;
    end else if (o_advance) begin
      o_tvalid <= i_valid;
      if (i_valid) begin
        o_tlast <= pkt_end;
        if (pkt_end) begin
          pkt_count <= '0;
        end else begin
          pkt_count <= pkt_count + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (o_advance && i_valid) begin
      o_tdata <= i_sample.raw;
    end
  end

endmodule

// ==== verilog/sine_tone.sv ====
/*
 * Streaming sine tone source
 * Settings registers, phase accumulator, CORDIC rotator and output framer
 */
`timescale 1ns/1ps

module sine_tone (
  input  logic                                  clk,
  input  logic                                  i_reset,
  input  logic                                  i_clear,
  input  logic                                  i_set_stb,
  input  logic [sine_tone_pkg::SET_ADDR_W-1:0]  i_set_addr,
  input  logic [sine_tone_pkg::SET_DATA_W-1:0]  i_set_data,
  input  logic                                  i_tready,
  output logic [sine_tone_pkg::IQ_W-1:0]        o_tdata,
  output logic                                  o_tlast,
  output logic                                  o_tvalid
);

  logic signed [sine_tone_pkg::PHASE_W-1:0] phase_inc;
  sine_tone_pkg::iq_sample_t                cartesian;
  logic [sine_tone_pkg::SPP_W-1:0]          spp;
  logic                                     enable;

  // Stall for the whole pipeline
  logic                                     advance;

  logic signed [sine_tone_pkg::PHASE_W-1:0] phase;
  logic                                     phase_valid;
  sine_tone_pkg::iq_sample_t                rot_sample;
  logic                                     rot_valid;

  tone_settings tone_settings_i (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_set_stb   (i_set_stb),
    .i_set_addr  (i_set_addr),
    .i_set_data  (i_set_data),
    .o_phase_inc (phase_inc),
    .o_cartesian (cartesian),
    .o_spp       (spp),
    .o_enable    (enable)
  );

  phase_accumulator phase_accumulator_i (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_clear       (i_clear),
    .i_advance     (advance),
    .i_enable      (enable),
    .i_phase_inc   (phase_inc),
    .o_phase       (phase),
    .o_phase_valid (phase_valid)
  );

  cordic_rotator cordic_rotator_i (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_clear       (i_clear),
    .i_advance     (advance),
    .i_phase       (phase),
    .i_phase_valid (phase_valid),
    .i_cartesian   (cartesian),
    .o_sample      (rot_sample),
    .o_valid       (rot_valid)
  );

  tone_framer tone_framer_i (
    .clk       (clk),
    .i_reset   (i_reset),
    .i_clear   (i_clear),
    .i_sample  (rot_sample),
    .i_valid   (rot_valid),
    .i_spp     (spp),
    .i_tready  (i_tready),
    .o_advance (advance),
    .o_tdata   (o_tdata),
    .o_tlast   (o_tlast),
    .o_tvalid  (o_tvalid)
  );

endmodule

// ==== bench/tone_cases.svh ====
/*
 * Tone test cases for the sine tone testbench
 * Columns: phase increment, start x (y is 0), spp, samples, tready percent, clear midway
 */
`ifndef TONE_CASES_SVH
`define TONE_CASES_SVH

typedef struct packed {
  logic signed [sine_tone_pkg::PHASE_W-1:0]  phase_inc;
  logic signed [sine_tone_pkg::SAMPLE_W-1:0] start_x;
  logic [sine_tone_pkg::SPP_W-1:0]           spp;
  int                                        count;
  int                                        ready_pct;
  bit                                        clear_mid;
} tone_case_t;

localparam int NUM_CASES = 6;

localparam tone_case_t TONE_CASES [NUM_CASES] = '{
  // Two tones at full rate, then the same tone louder
  '{16'sd41,   16'sd3000, 16'd64, 400, 100, 1'b0},
  '{16'sd82,   16'sd3000, 16'd64, 400, 100, 1'b0},
  '{16'sd82,   16'sd5000, 16'd7,  400, 100, 1'b0},
  // Back-pressure on about half the cycles
  '{16'sd123,  16'sd3000, 16'd7,  300, 50,  1'b0},
  // Clear halfway, sequence and packet count restart
  '{16'sd300,  16'sd4000, 16'd64, 200, 50,  1'b1},
  // Negative step, packet size 0 is stored as 1
  '{-16'sd517, 16'sd2000, 16'd0,  60,  70,  1'b0}
};

`endif

// ==== bench/sine_tone_tb.sv ====
/*
 * Testbench for the streaming sine tone source
 * Runs the tone case table against a floating point sine/cosine model
 */
`timescale 1ns/1ps

module sine_tone_tb;

  logic        clk;
  logic        i_reset;
  logic        i_clear;
  logic        i_set_stb;
  logic [7:0]  i_set_addr;
  logic [31:0] i_set_data;
  logic        i_tready;
  logic [31:0] o_tdata;
  logic        o_tlast;
  logic        o_tvalid;

  `include "tone_cases.svh"

  localparam int  TOL = 24;
  localparam int  DRAIN_LIMIT = 200;
  localparam real GAIN = 1.647;
  localparam real PI_R = 3.14159265358979;

  int err_count = 0;
  int test_count = 0;
  int test_fail = 0;
  int test_start = 0;
  bit timed_out = 1'b0;

  sine_tone sine_tone_i (
    .clk        (clk),
    .i_reset    (i_reset),
    .i_clear    (i_clear),
    .i_set_stb  (i_set_stb),
    .i_set_addr (i_set_addr),
    .i_set_data (i_set_data),
    .i_tready   (i_tready),
    .o_tdata    (o_tdata),
    .o_tlast    (o_tlast),
    .o_tvalid   (o_tvalid)
  );

  always #5 clk = ~clk;

  // Ideal rotation of (x, 0) by n steps, scaled by the CORDIC gain
  function automatic sine_tone_pkg::iq_sample_t model_sample(input int x, input int n,
                                                             input int inc);
    real amp;
    real ang;
    sine_tone_pkg::iq_sample_t s;
    amp = real'(x) * GAIN;
    ang = real'(n) * real'(inc) * PI_R / real'(sine_tone_pkg::PHASE_PI);
    s.iq.i = sine_tone_pkg::SAMPLE_W'(int'(amp * $cos(ang)));
    s.iq.q = sine_tone_pkg::SAMPLE_W'(int'(amp * $sin(ang)));
    return s;
  endfunction

  task automatic check_sample(input sine_tone_pkg::iq_sample_t got,
                              input sine_tone_pkg::iq_sample_t want);
    int di;
    int dq;
    di = int'(got.iq.i) - int'(want.iq.i);
    dq = int'(got.iq.q) - int'(want.iq.q);
    if (di > TOL || di < -TOL || dq > TOL || dq < -TOL) begin
      $display("ERR %0t o_tdata got i=%0d q=%0d exp i=%0d q=%0d", $time,
               got.iq.i, got.iq.q, want.iq.i, want.iq.q);
      err_count++;
    end
  endtask

  task automatic check_last(input bit got, input bit want);
    if (got !== want) begin
      $display("ERR %0t o_tlast got %0b exp %0b", $time, got, want);
      err_count++;
    end
  endtask

  task automatic check_valid(input bit got, input bit want);
    if (got !== want) begin
      $display("ERR %0t o_tvalid got %0b exp %0b", $time, got, want);
      err_count++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: the wait for %s expired", what);
    timed_out = 1'b1;
  endtask

  // Called on a falling edge, returns on the next one
  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    i_set_stb = 1'b1;
    i_set_addr = addr;
    i_set_data = data;
    @(negedge clk);
    i_set_stb = 1'b0;
  endtask

  task automatic pulse_clear();
    i_clear = 1'b1;
    i_tready = 1'b0;
    @(negedge clk);
    i_clear = 1'b0;
  endtask

  // Outputs are read on the falling edge, the transfer happens on the next rising edge
  task automatic collect_samples(input tone_case_t c, input int count);
    int n;
    int cycles;
    int spp_eff;
    bit ready;
    sine_tone_pkg::iq_sample_t got;
    n = 0;
    cycles = 0;
    spp_eff = (c.spp == 0) ? 1 : int'(c.spp);
    while (n < count && cycles < count * 10 + 100) begin
      ready = int'($urandom % 100) < c.ready_pct;
      i_tready = ready;
      if (o_tvalid && ready) begin
        got.raw = o_tdata;
        check_sample(got, model_sample(c.start_x, n, c.phase_inc));
        check_last(o_tlast, ((n + 1) % spp_eff) == 0);
        n++;
      end
      @(negedge clk);
      cycles++;
    end
    i_tready = 1'b0;
    if (n < count) begin
      report_timeout("tone samples");
    end
  endtask

  // Empty the pipeline until the output stays quiet for longer than its depth
  task automatic drain_stream();
    int quiet;
    int cycles;
    quiet = 0;
    cycles = 0;
    i_tready = 1'b1;
    while (quiet < sine_tone_pkg::CORDIC_LATENCY + 4 && cycles < DRAIN_LIMIT) begin
      quiet = o_tvalid ? 0 : quiet + 1;
      @(negedge clk);
      cycles++;
    end
    if (quiet < sine_tone_pkg::CORDIC_LATENCY + 4) begin
      report_timeout("the pipeline to drain after disable");
    end
  endtask

  task automatic expect_idle(input int cycles);
    i_tready = 1'b1;
    for (int k = 0; k < cycles; k++) begin
      check_valid(o_tvalid, 1'b0);
      @(negedge clk);
    end
  endtask

  task automatic end_test(input string name);
    test_count++;
    if (err_count != test_start || timed_out) begin
      test_fail++;
      $display("test %s: fail", name);
    end else begin
      $display("test %s: pass", name);
    end
  endtask

  task automatic run_case(input int k);
    tone_case_t c;
    sine_tone_pkg::iq_sample_t cart;
    c = TONE_CASES[k];
    test_start = err_count;
    cart.iq.i = c.start_x;
    cart.iq.q = '0;
    pulse_clear();
    write_reg(sine_tone_pkg::SR_PHASE_INC, {16'h0, c.phase_inc});
    write_reg(sine_tone_pkg::SR_CARTESIAN, cart.raw);
    write_reg(sine_tone_pkg::SR_SPP, {16'h0, c.spp});
    write_reg(sine_tone_pkg::SR_ENABLE, 32'd1);
    if (c.clear_mid) begin
      collect_samples(c, c.count / 2);
      // Clear while the tone is still enabled, so only the clear restarts the phase
      pulse_clear();
      write_reg(sine_tone_pkg::SR_ENABLE, 32'd1);
      collect_samples(c, c.count - c.count / 2);
    end else begin
      collect_samples(c, c.count);
    end
    write_reg(sine_tone_pkg::SR_ENABLE, 32'd0);
    drain_stream();
    expect_idle(50);
    end_test($sformatf("case %0d inc=%0d spp=%0d ready=%0d%%", k, c.phase_inc, c.spp,
                       c.ready_pct));
  endtask

  initial begin
    clk = 1'b0;
    i_reset = 1'b1;
    i_clear = 1'b0;
    i_set_stb = 1'b0;
    i_set_addr = '0;
    i_set_data = '0;
    i_tready = 1'b0;
    void'($urandom(32'h1a49));
    repeat (5) @(negedge clk);
    i_reset = 1'b0;
    test_start = err_count;
    expect_idle(50);
    end_test("idle after reset");
    for (int k = 0; k < NUM_CASES; k++) begin
      if (!timed_out) begin
        run_case(k);
      end
    end
    $display("tests %0d, failed %0d, errors %0d", test_count, test_fail, err_count);
    if (err_count == 0 && !timed_out) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+bench
verilog/sine_tone_pkg.sv
verilog/tone_settings.sv
verilog/phase_accumulator.sv
verilog/cordic_rotator.sv
verilog/tone_framer.sv
verilog/sine_tone.sv
bench/sine_tone_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the sine tone testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f filelist.f --top-module sine_tone_tb \
  -Mdir obj_dir -o sine_tone_sim > build.log 2>&1 \
  && ./obj_dir/sine_tone_sim > sim.log 2>&1 \
  || { echo "Build or simulation run failed, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "Simulation FAILED" sim.log && { echo "Testbench reported failure"; exit 1; }
echo "Testbench finished without failure"
exit 0
